// ==== src.f ====
uiq_pkg.sv
uiq_if.sv
dispatch_decoder.sv
issue_queue.sv
issue_port.sv
uiq_top.sv
tb_uiq.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the issue queue testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_uiq -o tb_uiq_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# output is kept in memory only.
out=$(./obj_dir/tb_uiq_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

echo "$out" | grep -q "TEST RESULT: PASS"
if [ $? -ne 0 ]; then
    exit 1
fi
exit 0

// ==== tb_uiq.sv ====
`timescale 1ns/1ps

module tb_uiq;
    import uiq_pkg::*;

    logic              clk;
    logic              rstn;
    logic              disp_valid;
    logic [xlen-1:0]   pc;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [preg_w-1:0] src1_tag;
    logic [preg_w-1:0] src2_tag;
    logic [preg_w-1:0] dest;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   src1_data;
    logic [xlen-1:0]   src2_data;
    logic              src1_ready;
    logic              src2_ready;
    logic              wb_valid;
    logic [preg_w-1:0] wb_tag;
    logic [xlen-1:0]   wb_data;
    logic [2:0]        alu_rdy;
    logic              stall;

    // issue outputs, one element per ALU.
    logic              iv [3];
    logic [xlen-1:0]   ipc [3];
    logic [3:0]        iop [3];
    logic [alu_w-1:0]  ialu [3];
    logic [rob_w-1:0]  irob [3];
    logic [preg_w-1:0] idest [3];
    logic [xlen-1:0]   is1 [3];
    logic [xlen-1:0]   is2 [3];
    logic [xlen-1:0]   iimm [3];

    // supported operations; index k issues as op code k + 1.
    logic [6:0] t_opc [10] = '{7'h33, 7'h13, 7'h37, 7'h13, 7'h33,
                               7'h13, 7'h03, 7'h03, 7'h23, 7'h23};
    logic [2:0] t_f3 [10]  = '{3'd0, 3'd0, 3'd0, 3'd6, 3'd4, 3'd5, 3'd0, 3'd2, 3'd0, 3'd2};
    bit         t_z1 [10]  = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    bit         t_z2 [10]  = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};

    // reference model, indexed by ROB number.
    bit                m_valid [64];
    bit                m_w1 [64];
    bit                m_w2 [64];
    logic [3:0]        m_op [64];
    logic [alu_w-1:0]  m_alu [64];
    logic [preg_w-1:0] m_dest [64];
    logic [preg_w-1:0] m_t1 [64];
    logic [preg_w-1:0] m_t2 [64];
    logic [xlen-1:0]   m_pc [64];
    logic [xlen-1:0]   m_imm [64];
    logic [xlen-1:0]   m_s1 [64];
    logic [xlen-1:0]   m_s2 [64];
    int                m_rob;
    int                m_alu_nxt;
    int                n_pending;
    int                n_sent;
    int                n_err;
    int                n_tmo;
    int                n_issued [3];
    logic [2:0]        rdy_prev;
    string             test_name;

    uiq_top #(
        .depth (8)
    ) u_dut (
        .clk (clk), .rstn (rstn), .disp_valid (disp_valid), .pc (pc), .opcode (opcode),
        .funct3 (funct3), .src1_tag (src1_tag), .src2_tag (src2_tag), .imm (imm),
        .dest (dest), .src1_data (src1_data), .src2_data (src2_data),
        .src1_ready (src1_ready), .src2_ready (src2_ready), .wb_valid (wb_valid),
        .wb_tag (wb_tag), .wb_data (wb_data), .alu_ready0 (alu_rdy[0]),
        .alu_ready1 (alu_rdy[1]), .alu_ready2 (alu_rdy[2]), .stall (stall),
        .issue_valid0 (iv[0]), .issue_pc0 (ipc[0]), .issue_op0 (iop[0]),
        .issue_alu0 (ialu[0]), .issue_rob0 (irob[0]), .issue_dest0 (idest[0]),
        .issue_src10 (is1[0]), .issue_src20 (is2[0]), .issue_imm0 (iimm[0]),
        .issue_valid1 (iv[1]), .issue_pc1 (ipc[1]), .issue_op1 (iop[1]),
        .issue_alu1 (ialu[1]), .issue_rob1 (irob[1]), .issue_dest1 (idest[1]),
        .issue_src11 (is1[1]), .issue_src21 (is2[1]), .issue_imm1 (iimm[1]),
        .issue_valid2 (iv[2]), .issue_pc2 (ipc[2]), .issue_op2 (iop[2]),
        .issue_alu2 (ialu[2]), .issue_rob2 (irob[2]), .issue_dest2 (idest[2]),
        .issue_src12 (is1[2]), .issue_src22 (is2[2]), .issue_imm2 (iimm[2])
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            n_err++;
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // one issue pulse against the model entry with the same ROB number.
    task automatic compare_issue(input int p);
        int r;
        r = int'(irob[p]);
        assert (rdy_prev[p]) else begin
            n_err++;
            $display("port %0d issued while its ALU was not ready", p);
        end
        assert (m_valid[r]) else begin
            n_err++;
            $display("port %0d issued ROB %0d, which was not waiting to issue", p, r);
        end
        if (m_valid[r]) begin
            assert (!m_w1[r] && !m_w2[r]) else begin
                n_err++;
                $display("ROB %0d issued before its source was woken up", r);
            end
            expect_eq("port", 32'(m_alu[r]), 32'(p));
            expect_eq("alu", 32'(m_alu[r]), 32'(ialu[p]));
            expect_eq("op", 32'(m_op[r]), 32'(iop[p]));
            expect_eq("pc", m_pc[r], ipc[p]);
            expect_eq("dest", 32'(m_dest[r]), 32'(idest[p]));
            expect_eq("imm", m_imm[r], iimm[p]);
            expect_eq("src1", m_s1[r], is1[p]);
            expect_eq("src2", m_s2[r], is2[p]);
            m_valid[r] = 1'b0;
            n_pending--;
            n_issued[p]++;
        end
    endtask

    // outputs settle at the rising edge, so they are sampled half a cycle later.
    always @(negedge clk) begin
        if (rstn) begin
            for (int p = 0; p < 3; p++) begin
                if (iv[p]) begin
                    compare_issue(p);
                end
            end
        end
        rdy_prev = alu_rdy;
    end

    // k 10 and 11 are unsupported encodings.
    task automatic dispatch_instr(input int k, input bit r1, input bit r2,
                                  input logic [preg_w-1:0] t1, input logic [preg_w-1:0] t2);
        int r;
        disp_valid = 1'b1;
        pc         = $urandom;
        imm        = $urandom;
        dest       = preg_w'($urandom);
        src1_data  = $urandom;
        src2_data  = $urandom;
        src1_tag   = t1;
        src2_tag   = t2;
        src1_ready = r1;
        src2_ready = r2;
        if (k < 10) begin
            opcode = t_opc[k];
            funct3 = (k == 2) ? 3'($urandom) : t_f3[k];
        end else if (k == 10) begin
            opcode = 7'h63;
            funct3 = 3'd0;
        end else begin
            opcode = 7'h33;
            funct3 = 3'd1;
        end
        // stall only moves on clock edges.
        if (k < 10 && !stall) begin
            r          = m_rob;
            m_valid[r] = 1'b1;
            m_op[r]    = 4'(k + 1);
            m_alu[r]   = alu_w'(m_alu_nxt);
            m_pc[r]    = pc;
            m_dest[r]  = dest;
            m_imm[r]   = imm;
            m_s1[r]    = t_z1[k] ? 32'd0 : src1_data;
            m_s2[r]    = t_z2[k] ? 32'd0 : src2_data;
            m_w1[r]    = !t_z1[k] && !r1;
            m_w2[r]    = !t_z2[k] && !r2;
            m_t1[r]    = t1;
            m_t2[r]    = t2;
            m_rob      = (m_rob + 1) % 64;
            m_alu_nxt  = (m_alu_nxt + 1) % 3;
            n_pending++;
            n_sent++;
        end
    endtask

    task automatic broadcast(input logic [preg_w-1:0] tag, input logic [xlen-1:0] data);
        wb_valid = 1'b1;
        wb_tag   = tag;
        wb_data  = data;
        for (int r = 0; r < 64; r++) begin
            if (m_valid[r] && m_w1[r] && m_t1[r] == tag) begin
                m_s1[r] = data;
                m_w1[r] = 1'b0;
            end
            if (m_valid[r] && m_w2[r] && m_t2[r] == tag) begin
                m_s2[r] = data;
                m_w2[r] = 1'b0;
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        disp_valid = 1'b0;
        wb_valid   = 1'b0;
    endtask

    task automatic send_when_free(input int k, input bit r1, input bit r2,
                                  input logic [preg_w-1:0] t1, input logic [preg_w-1:0] t2);
        int n;
        n = 0;
        while (stall && n < 100) begin
            next_cycle();
            n++;
        end
        if (stall) begin
            n_tmo++;
            $display("timeout in %s: stall stayed high and dispatch could not go on", test_name);
        end
        dispatch_instr(k, r1, r2, t1, t2);
        next_cycle();
    endtask

    // waiting tags live in 48 to 63, so cycling through them wakes everything.
    task automatic drain_queue();
        int n;
        n = 0;
        while (n_pending > 0 && n < 400) begin
            broadcast(preg_w'(48 + n % 16), $urandom);
            next_cycle();
            n++;
        end
        if (n_pending > 0) begin
            n_tmo++;
            $display("timeout in %s: %0d instructions never issued", test_name, n_pending);
        end
        repeat (2) next_cycle();
    endtask

    initial begin
        int before0;
        int before2;
        bit r1;
        bit r2;
        void'($urandom(32'h5a06));
        rstn       = 1'b0;
        disp_valid = 1'b0;
        pc         = '0;
        opcode     = '0;
        funct3     = '0;
        src1_tag   = '0;
        src2_tag   = '0;
        dest       = '0;
        imm        = '0;
        src1_data  = '0;
        src2_data  = '0;
        src1_ready = 1'b0;
        src2_ready = 1'b0;
        wb_valid   = 1'b0;
        wb_tag     = '0;
        wb_data    = '0;
        alu_rdy    = 3'b111;
        m_rob      = 0;
        m_alu_nxt  = 0;
        n_pending  = 0;
        n_sent     = 0;
        n_err      = 0;
        n_tmo      = 0;
        n_issued   = '{0, 0, 0};
        test_name  = "reset";
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        assert (!stall && !iv[0] && !iv[1] && !iv[2]) else begin
            n_err++;
            $display("stall or an issue valid was high right after reset");
        end
        // model expects ROB 0 on ALU 0 here.
        send_when_free(0, 1'b1, 1'b1, 6'd3, 6'd4);
        drain_queue();

        test_name = "decode";
        for (int k = 0; k < 12; k++) begin
            send_when_free(k, 1'b1, 1'b1, preg_w'($urandom % 48), preg_w'($urandom % 48));
        end
        drain_queue();

        test_name = "wakeup";
        send_when_free(0, 1'b0, 1'b1, 6'd60, 6'd1);
        repeat (8) next_cycle();
        assert (n_pending == 1) else begin
            n_err++;
            $display("an instruction with a waiting source issued without a broadcast");
        end
        broadcast(6'd60, $urandom);
        next_cycle();
        // broadcast in the same cycle as dispatch.
        dispatch_instr(4, 1'b1, 1'b0, 6'd2, 6'd61);
        broadcast(6'd61, $urandom);
        next_cycle();
        drain_queue();

        test_name = "backpressure";
        alu_rdy   = 3'b101;
        before0   = n_issued[0];
        before2   = n_issued[2];
        // blocked entries pile up until seven of them hold the queue full.
        for (int c = 0; c < 40; c++) begin
            dispatch_instr(int'($urandom % 10), 1'b1, 1'b1, preg_w'($urandom % 48),
                           preg_w'($urandom % 48));
            next_cycle();
        end
        assert (stall) else begin
            n_err++;
            $display("stall was low although ALU 1 entries filled the queue");
        end
        assert (n_issued[0] > before0 && n_issued[2] > before2) else begin
            n_err++;
            $display("ALU 0 or ALU 2 stopped issuing while ALU 1 was blocked");
        end
        alu_rdy = 3'b111;
        drain_queue();
        assert (!stall) else begin
            n_err++;
            $display("stall stayed high after the queue drained");
        end

        test_name = "random";
        for (int c = 0; c < 400; c++) begin
            for (int a = 0; a < 3; a++) begin
                alu_rdy[a] = ($urandom % 4 != 0);
            end
            if ($urandom % 4 != 0) begin
                r1 = ($urandom % 4 != 0);
                r2 = ($urandom % 4 != 0);
                dispatch_instr(int'($urandom % 12), r1, r2,
                               r1 ? preg_w'($urandom % 48) : preg_w'(48 + $urandom % 4),
                               r2 ? preg_w'($urandom % 48) : preg_w'(48 + $urandom % 4));
            end
            if ($urandom % 2 != 0) begin
                broadcast(preg_w'(48 + $urandom % 4), $urandom);
            end
            next_cycle();
        end
        alu_rdy = 3'b111;
        drain_queue();
        assert (n_sent > 64) else begin
            n_err++;
            $display("too few instructions for the ROB number to wrap from 63 to 0");
        end

        $display("errors: %0d failed checks, %0d timeouts", n_err, n_tmo);
        if (n_err == 0 && n_tmo == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // hard limit on the whole run.
    initial begin
        #1000000;
        $display("the simulation ran past its time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== uiq_top.sv ====
`timescale 1ns/1ps

module uiq_top #(
    parameter int depth = 16
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          disp_valid,
    input  logic [uiq_pkg::xlen-1:0]      pc,
    input  logic [6:0]                    opcode,
    input  logic [2:0]                    funct3,
    input  logic [uiq_pkg::preg_w-1:0]    src1_tag,
    input  logic [uiq_pkg::preg_w-1:0]    src2_tag,
    input  logic [uiq_pkg::xlen-1:0]      imm,
    input  logic [uiq_pkg::preg_w-1:0]    dest,
    input  logic [uiq_pkg::xlen-1:0]      src1_data,
    input  logic [uiq_pkg::xlen-1:0]      src2_data,
    input  logic                          src1_ready,
    input  logic                          src2_ready,
    input  logic                          wb_valid,
    input  logic [uiq_pkg::preg_w-1:0]    wb_tag,
    input  logic [uiq_pkg::xlen-1:0]      wb_data,
    input  logic                          alu_ready0,
    input  logic                          alu_ready1,
    input  logic                          alu_ready2,
    output logic                          stall,
    output logic                          issue_valid0,
    output logic [uiq_pkg::xlen-1:0]      issue_pc0,
    output uiq_pkg::op_t                  issue_op0,
    output logic [uiq_pkg::alu_w-1:0]     issue_alu0,
    output logic [uiq_pkg::rob_w-1:0]     issue_rob0,
    output logic [uiq_pkg::preg_w-1:0]    issue_dest0,
    output logic [uiq_pkg::xlen-1:0]      issue_src10,
    output logic [uiq_pkg::xlen-1:0]      issue_src20,
    output logic [uiq_pkg::xlen-1:0]      issue_imm0,
    output logic                          issue_valid1,
    output logic [uiq_pkg::xlen-1:0]      issue_pc1,
    output uiq_pkg::op_t                  issue_op1,
    output logic [uiq_pkg::alu_w-1:0]     issue_alu1,
    output logic [uiq_pkg::rob_w-1:0]     issue_rob1,
    output logic [uiq_pkg::preg_w-1:0]    issue_dest1,
    output logic [uiq_pkg::xlen-1:0]      issue_src11,
    output logic [uiq_pkg::xlen-1:0]      issue_src21,
    output logic [uiq_pkg::xlen-1:0]      issue_imm1,
    output logic                          issue_valid2,
    output logic [uiq_pkg::xlen-1:0]      issue_pc2,
    output uiq_pkg::op_t                  issue_op2,
    output logic [uiq_pkg::alu_w-1:0]     issue_alu2,
    output logic [uiq_pkg::rob_w-1:0]     issue_rob2,
    output logic [uiq_pkg::preg_w-1:0]    issue_dest2,
    output logic [uiq_pkg::xlen-1:0]      issue_src12,
    output logic [uiq_pkg::xlen-1:0]      issue_src22,
    output logic [uiq_pkg::xlen-1:0]      issue_imm2
);

    dispatch_if u_disp_if ();
    issue_if    u_iss0 ();
    issue_if    u_iss1 ();
    issue_if    u_iss2 ();

    // queue stall goes out and back into the decoder.
    assign stall = u_disp_if.stall;

    dispatch_decoder u_dec (
        .clk        (clk),
        .rstn       (rstn),
        .disp_valid (disp_valid),
        .stall      (stall),
        .pc         (pc),
        .opcode     (opcode),
        .funct3     (funct3),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .imm        (imm),
        .dest       (dest),
        .src1_data  (src1_data),
        .src2_data  (src2_data),
        .src1_ready (src1_ready),
        .src2_ready (src2_ready),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .wb_data    (wb_data),
        .disp       (u_disp_if.decoder)
    );

    issue_queue #(
        .depth (depth)
    ) u_iq (
        .clk      (clk),
        .rstn     (rstn),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_data  (wb_data),
        .disp     (u_disp_if.queue),
        .iss0     (u_iss0.queue),
        .iss1     (u_iss1.queue),
        .iss2     (u_iss2.queue)
    );

    issue_port u_port0 (
        .clk (clk), .rstn (rstn), .alu_ready (alu_ready0), .iss (u_iss0.port),
        .issue_valid (issue_valid0), .issue_pc (issue_pc0), .issue_op (issue_op0),
        .issue_alu (issue_alu0), .issue_rob (issue_rob0), .issue_dest (issue_dest0),
        .issue_src1 (issue_src10), .issue_src2 (issue_src20), .issue_imm (issue_imm0)
    );

    issue_port u_port1 (
        .clk (clk), .rstn (rstn), .alu_ready (alu_ready1), .iss (u_iss1.port),
        .issue_valid (issue_valid1), .issue_pc (issue_pc1), .issue_op (issue_op1),
        .issue_alu (issue_alu1), .issue_rob (issue_rob1), .issue_dest (issue_dest1),
        .issue_src1 (issue_src11), .issue_src2 (issue_src21), .issue_imm (issue_imm1)
    );

    issue_port u_port2 (
        .clk (clk), .rstn (rstn), .alu_ready (alu_ready2), .iss (u_iss2.port),
        .issue_valid (issue_valid2), .issue_pc (issue_pc2), .issue_op (issue_op2),
        .issue_alu (issue_alu2), .issue_rob (issue_rob2), .issue_dest (issue_dest2),
        .issue_src1 (issue_src12), .issue_src2 (issue_src22), .issue_imm (issue_imm2)
    );

endmodule

// ==== issue_port.sv ====
`timescale 1ns/1ps

module issue_port (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          alu_ready,
    issue_if.port                         iss,
    output logic                          issue_valid,
    output logic [uiq_pkg::xlen-1:0]      issue_pc,
    output uiq_pkg::op_t                  issue_op,
    output logic [uiq_pkg::alu_w-1:0]     issue_alu,
    output logic [uiq_pkg::rob_w-1:0]     issue_rob,
    output logic [uiq_pkg::preg_w-1:0]    issue_dest,
    output logic [uiq_pkg::xlen-1:0]      issue_src1,
    output logic [uiq_pkg::xlen-1:0]      issue_src2,
    output logic [uiq_pkg::xlen-1:0]      issue_imm
);
    import uiq_pkg::*;

    issue_t pay_q;

    assign iss.alu_ready = alu_ready;

    // one-cycle pulse per grant.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= iss.grant;
        end
    end

    // payload held until the next grant.
    always_ff @(posedge clk) begin
        if (iss.grant) begin
            pay_q <= iss.payload;
        end
    end

    assign issue_pc   = pay_q.pc;
    assign issue_op   = pay_q.op;
    assign issue_alu  = pay_q.alu;
    assign issue_rob  = pay_q.rob;
    assign issue_dest = pay_q.dest;
    assign issue_src1 = pay_q.src1_data;
    assign issue_src2 = pay_q.src2_data;
    assign issue_imm  = pay_q.imm;

endmodule

// ==== issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue #(
    parameter int depth = 16
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          wb_valid,
    input  logic [uiq_pkg::preg_w-1:0]    wb_tag,
    input  logic [uiq_pkg::xlen-1:0]      wb_data,
    dispatch_if.queue                     disp,
    issue_if.queue                        iss0,
    issue_if.queue                        iss1,
    issue_if.queue                        iss2
);
    import uiq_pkg::*;

    localparam int idx_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    uiq_entry_t         q [depth];
    logic [depth-1:0]   valid;
    logic [depth-1:0]   clear;
    logic [num_alu-1:0] alu_rdy;
    logic [num_alu-1:0] found;
    logic [num_alu-1:0] grant;
    logic [idx_w-1:0]   sel_idx [num_alu];
    issue_t             pay [num_alu];
    logic [idx_w-1:0]   wr_idx;
    logic [cnt_w-1:0]   free_cnt;

    function automatic issue_t to_issue(input uiq_entry_t e);
        issue_t p;
        p.pc        = e.pc;
        p.op        = e.op;
        p.alu       = e.alu;
        p.rob       = e.rob;
        p.dest      = e.dest;
        p.src1_data = e.src1_data;
        p.src2_data = e.src2_data;
        p.imm       = e.imm;
        return p;
    endfunction

    assign alu_rdy = {iss2.alu_ready, iss1.alu_ready, iss0.alu_ready};

    // per ALU, lowest ready entry wins; scanning downwards leaves the lowest.
    always_comb begin
        for (int a = 0; a < num_alu; a++) begin
            found[a]   = 1'b0;
            sel_idx[a] = '0;
            for (int i = depth - 1; i >= 0; i--) begin
                if (valid[i] && q[i].alu == alu_w'(a) && q[i].src1_rdy && q[i].src2_rdy) begin
                    found[a]   = 1'b1;
                    sel_idx[a] = idx_w'(i);
                end
            end
            pay[a] = to_issue(q[sel_idx[a]]);
        end
    end

    assign grant = found & alu_rdy;

    always_comb begin
        clear = '0;
        for (int a = 0; a < num_alu; a++) begin
            if (grant[a]) begin
                clear[sel_idx[a]] = 1'b1;
            end
        end
    end

    // lowest free slot and free count.
    always_comb begin
        wr_idx   = '0;
        free_cnt = '0;
        for (int i = depth - 1; i >= 0; i--) begin
            if (!valid[i]) begin
                wr_idx   = idx_w'(i);
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    // keep one slot spare for the instruction sitting in the decoder.
    assign disp.stall = (free_cnt <= cnt_w'(1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid <= '0;
        end else begin
            valid <= valid & ~clear;
            if (disp.valid) begin
                valid[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < depth; i++) begin
            q[i] <= apply_wakeup(q[i], wb_valid, wb_tag, wb_data);
        end
        // incoming entry also sees this cycle's broadcast.
        if (disp.valid) begin
            q[wr_idx] <= apply_wakeup(disp.entry, wb_valid, wb_tag, wb_data);
        end
    end

    assign iss0.grant   = grant[0];
    assign iss0.payload = pay[0];
    assign iss1.grant   = grant[1];
    assign iss1.payload = pay[1];
    assign iss2.grant   = grant[2];
    assign iss2.payload = pay[2];

endmodule

// ==== dispatch_decoder.sv ====
`timescale 1ns/1ps

module dispatch_decoder (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic                          disp_valid,
    input  logic                          stall,
    input  logic [uiq_pkg::xlen-1:0]      pc,
    input  logic [6:0]                    opcode,
    input  logic [2:0]                    funct3,
    input  logic [uiq_pkg::preg_w-1:0]    src1_tag,
    input  logic [uiq_pkg::preg_w-1:0]    src2_tag,
    input  logic [uiq_pkg::xlen-1:0]      imm,
    input  logic [uiq_pkg::preg_w-1:0]    dest,
    input  logic [uiq_pkg::xlen-1:0]      src1_data,
    input  logic [uiq_pkg::xlen-1:0]      src2_data,
    input  logic                          src1_ready,
    input  logic                          src2_ready,
    input  logic                          wb_valid,
    input  logic [uiq_pkg::preg_w-1:0]    wb_tag,
    input  logic [uiq_pkg::xlen-1:0]      wb_data,
    dispatch_if.decoder                   disp
);
    import uiq_pkg::*;

    op_t              op;
    logic             accept;
    uiq_entry_t       entry_d;
    uiq_entry_t       entry_q;
    logic             valid_q;
    logic [rob_w-1:0] rob_cnt;
    logic [alu_w-1:0] alu_cnt;

    // opcode and funct3 to operation type.
    always_comb begin
        op = op_none;
        case (opcode)
            7'b0110011: begin
                case (funct3)
                    3'b000:  op = op_add;
                    3'b100:  op = op_xor;
                    default: op = op_none;
                endcase
            end
            7'b0010011: begin
                case (funct3)
                    3'b000:  op = op_addi;
                    3'b101:  op = op_srai;
                    3'b110:  op = op_ori;
                    default: op = op_none;
                endcase
            end
            7'b0110111: op = op_lui;
            7'b0000011: begin
                case (funct3)
                    3'b000:  op = op_lb;
                    3'b010:  op = op_lw;
                    default: op = op_none;
                endcase
            end
            7'b0100011: begin
                case (funct3)
                    3'b000:  op = op_sb;
                    3'b010:  op = op_sw;
                    default: op = op_none;
                endcase
            end
            default: op = op_none;
        endcase
    end

    assign accept = disp_valid && !stall && (op != op_none);

    always_comb begin
        uiq_entry_t e;
        e.pc        = pc;
        e.op        = op;
        e.alu       = alu_cnt;
        e.rob       = rob_cnt;
        e.dest      = dest;
        e.src1_tag  = src1_tag;
        e.src1_rdy  = src1_ready;
        e.src1_data = src1_data;
        e.src2_tag  = src2_tag;
        e.src2_rdy  = src2_ready;
        e.src2_data = src2_data;
        e.imm       = imm;
        // operands the operation never reads.
        if (op == op_lui) begin
            e.src1_rdy  = 1'b1;
            e.src1_data = '0;
        end
        if (op inside {op_lui, op_ori, op_srai, op_addi, op_lw, op_lb}) begin
            e.src2_rdy  = 1'b1;
            e.src2_data = '0;
        end
        entry_d = apply_wakeup(e, wb_valid, wb_tag, wb_data);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            rob_cnt <= '0;
            alu_cnt <= '0;
        end else begin
            valid_q <= accept;
            if (accept) begin
                // rob number wraps naturally at 64.
                rob_cnt <= rob_cnt + 1'b1;
                alu_cnt <= (alu_cnt == alu_w'(num_alu - 1)) ? '0 : alu_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            entry_q <= entry_d;
        end
    end

    assign disp.valid = valid_q;
    assign disp.entry = entry_q;

endmodule

// ==== uiq_if.sv ====
`timescale 1ns/1ps

// decoder register to queue.
interface dispatch_if;
    import uiq_pkg::*;

    logic       valid;
    uiq_entry_t entry;
    logic       stall;

    // stall reaches the decoder through a plain port at the top.
    modport decoder (
        output valid,
        output entry
    );

    modport queue (
        input  valid,
        input  entry,
        output stall
    );
endinterface

// one per ALU, queue select to issue port.
interface issue_if;
    import uiq_pkg::*;

    logic   grant;
    issue_t payload;
    logic   alu_ready;

    modport queue (
        output grant,
        output payload,
        input  alu_ready
    );

    modport port (
        input  grant,
        input  payload,
        output alu_ready
    );
endinterface

// ==== uiq_pkg.sv ====
package uiq_pkg;

    localparam int xlen    = 32;
    localparam int preg_w  = 6;
    localparam int rob_w   = 6;
    localparam int num_alu = 3;
    localparam int alu_w   = 2;

    // operation codes as used by the ALUs.
    typedef enum logic [3:0] {
        op_none = 4'd0,
        op_add  = 4'd1,
        op_addi = 4'd2,
        op_lui  = 4'd3,
        op_ori  = 4'd4,
        op_xor  = 4'd5,
        op_srai = 4'd6,
        op_lb   = 4'd7,
        op_lw   = 4'd8,
        op_sb   = 4'd9,
        op_sw   = 4'd10
    } op_t;

    typedef struct packed {
        logic [xlen-1:0]   pc;
        op_t               op;
        logic [alu_w-1:0]  alu;
        logic [rob_w-1:0]  rob;
        logic [preg_w-1:0] dest;
        logic [preg_w-1:0] src1_tag;
        logic              src1_rdy;
        logic [xlen-1:0]   src1_data;
        logic [preg_w-1:0] src2_tag;
        logic              src2_rdy;
        logic [xlen-1:0]   src2_data;
        logic [xlen-1:0]   imm;
    } uiq_entry_t;

    // what leaves the queue towards an ALU.
    typedef struct packed {
        logic [xlen-1:0]   pc;
        op_t               op;
        logic [alu_w-1:0]  alu;
        logic [rob_w-1:0]  rob;
        logic [preg_w-1:0] dest;
        logic [xlen-1:0]   src1_data;
        logic [xlen-1:0]   src2_data;
        logic [xlen-1:0]   imm;
    } issue_t;

    // capture a result broadcast into any waiting source of one entry.
    function automatic uiq_entry_t apply_wakeup(input uiq_entry_t e, input logic v,
                                                input logic [preg_w-1:0] tag,
                                                input logic [xlen-1:0] data);
        uiq_entry_t r;
        r = e;
        if (v && !e.src1_rdy && e.src1_tag == tag) begin
            r.src1_rdy  = 1'b1;
            r.src1_data = data;
        end
        if (v && !e.src2_rdy && e.src2_tag == tag) begin
            r.src2_rdy  = 1'b1;
            r.src2_data = data;
        end
        return r;
    endfunction

endpackage
